// ==== logic/dma_defines.svh ====
// widths, register strobe indices and device codes of the DMA engine
// register indices are bit positions in the CPU write strobe vector
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_ADDR_W      21
`define DMA_DATA_W      16
`define DMA_NREGS       9

`define DMA_REG_SADDRL  0
`define DMA_REG_SADDRH  1
`define DMA_REG_SADDRX  2
`define DMA_REG_DADDRL  3
`define DMA_REG_DADDRH  4
`define DMA_REG_DADDRX  5
`define DMA_REG_LEN     6
`define DMA_REG_CTRL    7
`define DMA_REG_NUM     8

`define DMA_DEV_RAM     3'd1
`define DMA_DEV_SPI     3'd2
`define DMA_DEV_CRAM    3'd4

`endif

// ==== logic/dma_cfg_pkg.sv ====
// CPU side types of the DMA engine
// control byte keeps the bit layout of the CPU register, bit 6 is unused
`include "dma_defines.svh"

package dma_cfg_pkg;

    typedef enum logic [2:0]
    {
        DEV_RAM  = `DMA_DEV_RAM,
        DEV_SPI  = `DMA_DEV_SPI,
        DEV_CRAM = `DMA_DEV_CRAM
    } dma_dev_e;

    typedef struct packed
    {
        logic     wnr;      // 0 device to RAM, 1 RAM to device
        logic     rsvd;
        logic     salgn;    // source aligned mode
        logic     dalgn;    // destination aligned mode
        logic     asz;      // stride 256 words when set
        dma_dev_e dev;
    } dma_ctrl_t;

    typedef union packed
    {
        logic [7:0] raw;
        dma_ctrl_t  ctrl;
    } dma_wdata_u;

    typedef struct packed
    {
        logic [`DMA_NREGS-1:0] stb;   // one bit per register
        dma_wdata_u            wdata;
    } dma_cpu_wr_t;

    // per channel view of the config
    typedef struct packed
    {
        logic algn;
        logic asz;
        logic ld_l;
        logic ld_h;
        logic ld_x;
    } dma_chan_cfg_t;

endpackage

// ==== logic/dma_bus_pkg.sv ====
// memory and device side types of the DMA engine
// every request is held until its answer strobe
`include "dma_defines.svh"

package dma_bus_pkg;

    // DRAM port
    typedef struct packed
    {
        logic [`DMA_ADDR_W-1:0] addr;
        logic [`DMA_DATA_W-1:0] wrdata;
        logic                   rnw;
        logic                   req;
    } dram_req_t;

    // SPI byte port, FF goes out while reading
    typedef struct packed
    {
        logic [7:0] wrdata;
        logic       req;
    } spi_out_t;

    // colour RAM is write only and takes one cycle
    typedef struct packed
    {
        logic                   we;
        logic [7:0]             addr;   // low destination byte
        logic [`DMA_DATA_W-1:0] data;
    } cram_wr_t;

endpackage

// ==== logic/dma_regs.sv ====
// CPU register file of the DMA engine
// writes are dropped while a transfer runs
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_regs
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  dma_cfg_pkg::dma_cpu_wr_t    cpu_wr,
    input  logic                        active,
    output dma_cfg_pkg::dma_ctrl_t      ctrl,
    output logic [7:0]                  len,
    output logic [7:0]                  num,
    output dma_cfg_pkg::dma_chan_cfg_t  src_cfg,
    output dma_cfg_pkg::dma_chan_cfg_t  dst_cfg,
    output logic [7:0]                  wbyte,
    output logic                        launch
);

    logic [`DMA_NREGS-1:0] wr_stb;

    assign wr_stb = cpu_wr.stb & {`DMA_NREGS{~active}};   // blocked while busy
    assign wbyte  = cpu_wr.wdata.raw;
    assign launch = wr_stb[`DMA_REG_CTRL];     // ctrl write starts the transfer

    // control byte through the field view
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ctrl <= '0;
        else if (launch)
            ctrl <= cpu_wr.wdata.ctrl;
    end

    always_ff @(posedge clk)
    begin
        if (wr_stb[`DMA_REG_LEN])
            len <= cpu_wr.wdata.raw;    // words per burst minus one
        if (wr_stb[`DMA_REG_NUM])
            num <= cpu_wr.wdata.raw;    // bursts minus one
    end

    always_comb
    begin
        src_cfg.algn = ctrl.salgn;
        src_cfg.asz  = ctrl.asz;
        src_cfg.ld_l = wr_stb[`DMA_REG_SADDRL];
        src_cfg.ld_h = wr_stb[`DMA_REG_SADDRH];
        src_cfg.ld_x = wr_stb[`DMA_REG_SADDRX];
    end

    // destination uses the same stride size
    always_comb
    begin
        dst_cfg.algn = ctrl.dalgn;
        dst_cfg.asz  = ctrl.asz;
        dst_cfg.ld_l = wr_stb[`DMA_REG_DADDRL];
        dst_cfg.ld_h = wr_stb[`DMA_REG_DADDRH];
        dst_cfg.ld_x = wr_stb[`DMA_REG_DADDRX];
    end

endmodule

// ==== logic/dma_addr_gen.sv ====
// one DMA address channel with linear or aligned stepping
// low register byte holds address bits 6..0 in its upper seven bits
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_addr_gen
(
    input  logic                        clk,
    input  dma_cfg_pkg::dma_chan_cfg_t  cfg,
    input  logic [7:0]                  wbyte,
    input  logic                        step,
    input  logic                        burst_end,
    output logic [`DMA_ADDR_W-1:0]      addr
);

    logic [7:0]  base_l;    // low byte of the burst line start
    logic [8:0]  inc_l;
    logic [1:0]  add_h;
    logic [13:0] next_h;
    logic [7:0]  next_l;
    logic        next_m;

    assign inc_l = {1'b0, addr[7:0]} + 9'd1;

    // aligned mode adds 128 or 256 words per burst, linear takes the carry
    assign add_h = cfg.algn ? {burst_end & cfg.asz, burst_end & ~cfg.asz}
                            : {inc_l[8], 1'b0};

    assign next_h = addr[`DMA_ADDR_W-1:7] + {12'd0, add_h};
    assign next_l = (cfg.algn && burst_end) ? base_l : inc_l[7:0];

    // bit 7 belongs to the low byte only with the 256 word stride
    always_comb
    begin
        if (!cfg.algn)
            next_m = inc_l[7];
        else if (cfg.asz)
            next_m = next_l[7];
        else
            next_m = next_h[0];
    end

    always_ff @(posedge clk)
    begin
        if (step)
            addr <= {next_h[13:1], next_m, next_l[6:0]};
        else
        begin
            if (cfg.ld_l)
            begin
                addr[6:0]   <= wbyte[7:1];
                base_l[6:0] <= wbyte[7:1];
            end
            if (cfg.ld_h)
            begin
                addr[14:7] <= wbyte;
                base_l[7]  <= wbyte[0];     // kept for the burst reload
            end
            if (cfg.ld_x)
                addr[`DMA_ADDR_W-1:15] <= wbyte[5:0];
        end
    end

endmodule

// ==== logic/dma_engine.sv ====
// DMA phase sequencer, one word in flight at a time
// each word is a read phase then a write phase, SPI words are two bytes low first
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_engine
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        launch,
    input  dma_cfg_pkg::dma_ctrl_t      ctrl,
    input  logic [7:0]                  len,
    input  logic [7:0]                  num,
    input  logic [`DMA_ADDR_W-1:0]      src_addr,
    input  logic [`DMA_ADDR_W-1:0]      dst_addr,
    input  logic [`DMA_DATA_W-1:0]      dram_rddata,
    input  logic                        dram_next,
    input  logic [7:0]                  spi_rddata,
    input  logic                        spi_stb,
    output dma_bus_pkg::dram_req_t      dram,
    output dma_bus_pkg::spi_out_t       spi,
    output dma_bus_pkg::cram_wr_t       cram,
    output logic                        step_src,
    output logic                        step_dst,
    output logic                        burst_end,
    output logic                        active
);

    logic                   phase;      // 0 read, 1 write
    logic                   bsel;       // SPI byte, 0 low
    logic [`DMA_DATA_W-1:0] data;
    logic [7:0]             b_ctr;      // words left in burst
    logic [8:0]             n_ctr;      // bursts left, bit 8 set when idle
    logic [8:0]             b_ctr_dec;
    logic [8:0]             n_ctr_dec;
    logic                   dv_ram;
    logic                   dv_spi;
    logic                   dv_crm;
    logic                   state_mem;
    logic                   state_dev;
    logic                   spi_int_stb;
    logic                   phase_end;

    assign dv_ram = (ctrl.dev == dma_cfg_pkg::DEV_RAM);
    assign dv_spi = (ctrl.dev == dma_cfg_pkg::DEV_SPI);
    assign dv_crm = (ctrl.dev == dma_cfg_pkg::DEV_CRAM) && ctrl.wnr;   // write only

    // RAM to RAM uses memory in both phases
    assign state_mem = dv_ram | (ctrl.wnr ^ phase);
    assign state_dev = ~dv_ram & (ctrl.wnr ^ ~phase);

    always_comb
    begin
        dram.req    = active & state_mem;
        dram.rnw    = ~phase;
        dram.addr   = phase ? dst_addr : src_addr;
        dram.wrdata = data;
        spi.req     = active & state_dev & dv_spi;
        spi.wrdata  = {8{~phase}} | (bsel ? data[15:8] : data[7:0]);  // FF while reading
        cram.we     = active & state_dev & dv_crm & phase;
        cram.addr   = dst_addr[7:0];
        cram.data   = data;
    end

    assign spi_int_stb = spi.req & spi_stb;
    assign phase_end   = (dram.req & dram_next) | cram.we | (spi_int_stb & bsel);

    assign step_src = phase_end & ~phase;
    assign step_dst = phase_end & phase;

    assign b_ctr_dec = {1'b0, b_ctr} - 9'd1;
    assign burst_end = b_ctr_dec[8];            // last word of the burst
    assign n_ctr_dec = n_ctr - {8'd0, burst_end};
    assign active    = ~n_ctr[8];

    // read phase data capture
    always_ff @(posedge clk)
    begin
        if (!phase && dram.req && dram_next)
            data <= dram_rddata;
        if (!phase && spi_int_stb)
        begin
            if (bsel)
                data[15:8] <= spi_rddata;
            else
                data[7:0] <= spi_rddata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            phase <= 1'b0;
            bsel  <= 1'b0;
        end
        else
        begin
            if (phase_end)
                phase <= ~phase;
            if (spi_int_stb)
                bsel <= ~bsel;
        end
    end

    // counters step on each completed write phase
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            n_ctr[8] <= 1'b1;
        else if (launch)
        begin
            b_ctr <= len;
            n_ctr <= {1'b0, num};
        end
        else if (phase && phase_end)
        begin
            b_ctr <= burst_end ? len : b_ctr_dec[7:0];
            n_ctr <= n_ctr_dec;     // wraps to idle after the last burst
        end
    end

endmodule

// ==== logic/dma_top.sv ====
// DMA engine top level for an 8-bit CPU and a 16-bit DRAM of 2M words
// targets are RAM, SPI and colour RAM only
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_top
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  dma_cfg_pkg::dma_cpu_wr_t    cpu_wr,
    input  logic [`DMA_DATA_W-1:0]      dram_rddata,
    input  logic                        dram_next,
    input  logic [7:0]                  spi_rddata,
    input  logic                        spi_stb,
    output dma_bus_pkg::dram_req_t      dram,
    output dma_bus_pkg::spi_out_t       spi,
    output dma_bus_pkg::cram_wr_t       cram,
    output logic                        active
);

    dma_cfg_pkg::dma_ctrl_t     ctrl;
    dma_cfg_pkg::dma_chan_cfg_t src_cfg;
    dma_cfg_pkg::dma_chan_cfg_t dst_cfg;
    logic [7:0]                 len;
    logic [7:0]                 num;
    logic [7:0]                 wbyte;
    logic                       launch;
    logic                       step_src;
    logic                       step_dst;
    logic                       burst_end;
    logic [`DMA_ADDR_W-1:0]     src_addr;
    logic [`DMA_ADDR_W-1:0]     dst_addr;

    dma_regs regs (.clk, .rst_n, .cpu_wr, .active, .ctrl, .len, .num,
                   .src_cfg, .dst_cfg, .wbyte, .launch);

    dma_addr_gen src_gen (.clk, .cfg(src_cfg), .wbyte, .step(step_src),
                          .burst_end, .addr(src_addr));

    dma_addr_gen dst_gen (.clk, .cfg(dst_cfg), .wbyte, .step(step_dst),
                          .burst_end, .addr(dst_addr));

    dma_engine engine (.clk, .rst_n, .launch, .ctrl, .len, .num, .src_addr, .dst_addr,
                       .dram_rddata, .dram_next, .spi_rddata, .spi_stb, .dram, .spi,
                       .cram, .step_src, .step_dst, .burst_end, .active);

endmodule

// ==== tests/tb_dma.sv ====
// testbench for dma_top, stimulus and expected values come from tests/dma_stimulus.txt
// run from the project root, DRAM and SPI answer after 0 to 3 random wait cycles
`timescale 1ns/1ps
`include "dma_defines.svh"

module tb_dma;

    localparam int CLK_HALF = 20;
    localparam string STIM_FILE = "tests/dma_stimulus.txt";

    logic                            clk = 1'b0;
    logic                            rst_n;
    dma_cfg_pkg::dma_cpu_wr_t        cpu_wr;
    logic [`DMA_DATA_W-1:0]          dram_rddata = '0;
    logic                            dram_next = 1'b0;
    logic [7:0]                      spi_rddata = '0;
    logic                            spi_stb = 1'b0;
    dma_bus_pkg::dram_req_t          dram;
    dma_bus_pkg::spi_out_t           spi;
    dma_bus_pkg::cram_wr_t           cram;
    logic                            active;

    logic [`DMA_DATA_W-1:0]          dram_mem [logic [`DMA_ADDR_W-1:0]];
    logic [7:0]                      spi_rd_q [$];     // bytes the SPI device returns
    logic [7:0]                      spi_wr_q [$];     // bytes the DMA sent
    dma_bus_pkg::cram_wr_t           cram_q [$];
    logic [31:0]                     lfsr = 32'h6eeb;
    int                              dram_wait = 0;
    int                              spi_wait = 0;
    logic                            dram_busy = 1'b0;
    logic                            spi_busy = 1'b0;
    int                              watchdog_cycles = 0;

    dma_top dma_top_inst (.clk, .rst_n, .cpu_wr, .dram_rddata, .dram_next, .spi_rddata,
                          .spi_stb, .dram, .spi, .cram, .active);

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    // two bits, one LFSR step each
    task automatic draw_wait(output int cycles);
        cycles = 0;
        repeat (2)
        begin
            lfsr   = lfsr_next(lfsr);
            cycles = cycles * 2 + int'(lfsr[0]);
        end
    endtask

    // unwritten DRAM words
    function automatic logic [15:0] fill_word(input logic [`DMA_ADDR_W-1:0] a);
        return a[15:0] ^ {a[20:16], 11'h2a5};
    endfunction

    function automatic logic [15:0] read_mem(input logic [`DMA_ADDR_W-1:0] a);
        if (dram_mem.exists(a))
            return dram_mem[a];
        return fill_word(a);
    endfunction

    // DRAM, SPI and CRAM models, sampled and driven 2 ns after the edge
    always @(posedge clk)
    begin
        #2;
        dram_next = 1'b0;
        spi_stb   = 1'b0;
        if (rst_n && dram.req)
        begin
            if (!dram_busy)
            begin
                dram_busy = 1'b1;
                draw_wait(dram_wait);
            end
            if (dram_wait == 0)
            begin
                dram_busy = 1'b0;
                dram_next = 1'b1;
                if (dram.rnw)
                    dram_rddata = read_mem(dram.addr);
                else
                    dram_mem[dram.addr] = dram.wrdata;
            end
            else
                dram_wait--;
        end
        if (rst_n && spi.req)
        begin
            if (!spi_busy)
            begin
                spi_busy = 1'b1;
                draw_wait(spi_wait);
            end
            if (spi_wait == 0)
            begin
                spi_busy   = 1'b0;
                spi_stb    = 1'b1;
                spi_rddata = (spi_rd_q.size() > 0) ? spi_rd_q.pop_front() : 8'hff;
                spi_wr_q.push_back(spi.wrdata);
            end
            else
                spi_wait--;
        end
        if (rst_n && cram.we)
            cram_q.push_back(cram);     // one cycle per write
    end

    task automatic report_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_dram_word(input logic [`DMA_ADDR_W-1:0] a,
                                   input logic [`DMA_DATA_W-1:0] exp);
        logic [`DMA_DATA_W-1:0] got;
        got = read_mem(a);
        if (got !== exp)
        begin
            $display("FAIL dram[%06h]: got %04h expected %04h", a, got, exp);
            report_failure();
        end
    endtask

    task automatic check_spi_byte(input logic [7:0] exp);
        logic [7:0] got;
        if (spi_wr_q.size() == 0)
        begin
            $display("an SPI byte was expected but the DMA sent none");
            report_failure();
        end
        else
        begin
            got = spi_wr_q.pop_front();
            if (got !== exp)
            begin
                $display("FAIL spi.wrdata: got %02h expected %02h", got, exp);
                report_failure();
            end
        end
    endtask

    task automatic check_cram(input dma_bus_pkg::cram_wr_t exp);
        dma_bus_pkg::cram_wr_t got;
        if (cram_q.size() == 0)
        begin
            $display("a colour RAM write was expected but none happened");
            report_failure();
        end
        else
        begin
            got = cram_q.pop_front();
            if (got !== exp)
            begin
                $display("FAIL cram: got addr %02h data %04h expected addr %02h data %04h",
                         got.addr, got.data, exp.addr, exp.data);
                report_failure();
            end
        end
    endtask

    task automatic check_active(input logic exp);
        if (active !== exp)
        begin
            $display("FAIL active: got %h expected %h", active, exp);
            report_failure();
        end
    endtask

    // one strobe cycle, called 2 ns after an edge
    task automatic write_reg(input int idx, input logic [7:0] val);
        cpu_wr           = '0;
        cpu_wr.stb[idx]  = 1'b1;
        cpu_wr.wdata.raw = val;
        @(posedge clk);
        #2;
        cpu_wr = '0;
    endtask

    task automatic wait_done();
        check_active(1'b1);     // the launch started a transfer
        while (active === 1'b1)
        begin
            @(posedge clk);
            #2;
        end
        check_active(1'b0);
    endtask

    initial
    begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the transfers did not end within %0d cycles", watchdog_cycles);
        report_failure();
    end

    initial
    begin
        int                      fd;
        int                      r;
        int                      n;
        int                      idx;
        int                      exp_words;
        logic [63:0]             kind;
        logic [`DMA_ADDR_W-1:0]  addr;
        logic [`DMA_DATA_W-1:0]  word;
        logic [7:0]              b;
        string                   line;
        dma_bus_pkg::cram_wr_t   exp_cram;

        rst_n  = 1'b0;
        cpu_wr = '0;

        // count expected words for the watchdog
        exp_words = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            report_failure();
        end
        while (!$feof(fd))
        begin
            line = "";
            r = $fgets(line, fd);
            kind = '0;
            n = 0;
            if (r > 0 && $sscanf(line, "%s", kind) == 1)
            begin
                if (kind == "E")
                    r = $sscanf(line, "%s %h %d", kind, addr, n);
                else if (kind == "Y")
                    r = $sscanf(line, "%s %d", kind, n);
                else if (kind == "C")
                    n = 1;
                exp_words += n;
            end
        end
        $fclose(fd);
        watchdog_cycles = 200 * exp_words + 1000;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        fd = $fopen(STIM_FILE, "r");
        while ($fscanf(fd, "%s", kind) == 1)
        begin
            if (kind == "#")
                r = $fgets(line, fd);
            else if (kind == "P")
            begin
                r = $fscanf(fd, "%h %d", addr, n);
                for (int i = 0; i < n; i++)
                begin
                    r = $fscanf(fd, "%h", word);
                    dram_mem[addr + `DMA_ADDR_W'(i)] = word;
                end
            end
            else if (kind == "S")
            begin
                r = $fscanf(fd, "%d", n);
                repeat (n)
                begin
                    r = $fscanf(fd, "%h", b);
                    spi_rd_q.push_back(b);
                end
            end
            else if (kind == "W")
            begin
                r = $fscanf(fd, "%d %h", idx, b);
                write_reg(idx, b);
            end
            else if (kind == "D")
                wait_done();
            else if (kind == "E")
            begin
                r = $fscanf(fd, "%h %d", addr, n);
                for (int i = 0; i < n; i++)
                begin
                    r = $fscanf(fd, "%h", word);
                    check_dram_word(addr + `DMA_ADDR_W'(i), word);
                end
            end
            else if (kind == "Y")
            begin
                r = $fscanf(fd, "%d", n);
                repeat (n)
                begin
                    r = $fscanf(fd, "%h", b);
                    check_spi_byte(b);
                end
            end
            else if (kind == "C")
            begin
                r = $fscanf(fd, "%h %h", b, word);
                exp_cram.we   = 1'b1;
                exp_cram.addr = b;
                exp_cram.data = word;
                check_cram(exp_cram);
            end
            else
            begin
                $display("unknown line kind in the stimulus file");
                report_failure();
            end
        end
        $fclose(fd);

        if (spi_wr_q.size() != 0 || cram_q.size() != 0)
        begin
            $display("the DMA sent more device data than expected");
            report_failure();
        end
        else
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== tests/dma_stimulus.txt ====
# P addr n words | S n bytes | W reg byte | D wait for idle
# E addr n words | Y n bytes | C cram_addr data, all values hex except counts and reg
# linear RAM to RAM, 2 bursts of 3 words, 0x100 to 0x200
P 100 6 1a01 2b02 3c03 4d04 5e05 6f06
W 0 00
W 1 02
W 2 00
W 3 00
W 4 04
W 5 00
W 6 02
W 8 01
W 7 01
D
E 200 6 1a01 2b02 3c03 4d04 5e05 6f06
# aligned destination, 128 word stride, 2 bursts of 4 words to 0x107e
P 300 8 c100 c101 c102 c103 c104 c105 c106 c107
W 0 00
W 1 06
W 2 00
W 3 fc
W 4 20
W 5 00
W 6 03
W 8 01
W 7 11
D
E 107e 2 c100 c101
E 1000 2 c102 c103
E 10fe 2 c104 c105
E 1080 2 c106 c107
# aligned destination, 256 word stride, 2 bursts of 3 words to 0x20fe
P 400 6 d200 d201 d202 d203 d204 d205
W 0 00
W 1 08
W 2 00
W 3 fc
W 4 41
W 5 00
W 6 02
W 8 01
W 7 19
D
E 20fe 2 d200 d201
E 2000 1 d202
E 21fe 2 d203 d204
E 2100 1 d205
# SPI to RAM, 2 words to 0x3000
S 4 11 22 33 44
W 3 00
W 4 60
W 5 00
W 6 01
W 8 00
W 7 02
D
E 3000 2 2211 4433
Y 4 ff ff ff ff
# RAM to SPI from 0x500
P 500 2 a1b2 c3d4
W 0 00
W 1 0a
W 2 00
W 6 01
W 8 00
W 7 82
D
Y 4 b2 a1 d4 c3
# RAM to colour RAM from 0x600, destination byte 0x10
P 600 3 e001 e002 e003
W 0 00
W 1 0c
W 2 00
W 3 20
W 4 00
W 5 00
W 6 02
W 8 00
W 7 84
D
C 10 e001
C 11 e002
C 12 e003
# length write during a transfer is dropped
P 700 7 f700 f701 f702 f703 f704 f705 f706
P 804 1 5a5a
W 0 00
W 1 0e
W 2 00
W 3 00
W 4 10
W 5 00
W 6 01
W 8 00
W 7 01
W 6 05
D
E 800 2 f700 f701
W 7 01
D
E 802 3 f702 f703 5a5a
W 6 02
W 7 01
D
E 804 3 f704 f705 f706

// ==== build.f ====
+incdir+logic
logic/dma_cfg_pkg.sv
logic/dma_bus_pkg.sv
logic/dma_regs.sv
logic/dma_addr_gen.sv
logic/dma_engine.sv
logic/dma_top.sv
tests/tb_dma.sv

// ==== Makefile ====
# Verilator flow for the DMA engine, run from the project root

VERILATOR  ?= verilator
TOP        ?= tb_dma
RTL_TOP    ?= dma_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+logic logic/dma_cfg_pkg.sv logic/dma_bus_pkg.sv \
		logic/dma_regs.sv logic/dma_addr_gen.sv logic/dma_engine.sv logic/dma_top.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
